// ==== demux_pkg.sv ====
// Shared widths, types and memory-map constants for the core data demux; referenced by scoped names
package demux_pkg;

  // Bus widths
  parameter int unsigned ADDR_WIDTH = 32;
  parameter int unsigned DATA_WIDTH = 32;
  parameter int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;
  typedef logic [3:0]            nibble_t;
  typedef logic [5:0]            cluster_id_t;
  typedef logic [11:0]           region_t;

  // Cluster regions start here, four region tags per cluster
  parameter region_t CLUSTER_REGION_BASE = 12'h100;

  // Offsets inside one cluster's group of four
  parameter region_t TCDM_RW_OFS = 12'd0;
  parameter region_t TCDM_TS_OFS = 12'd1;
  parameter region_t DEM_PER_OFS = 12'd2;

  // Inside the peripheral region this bit picks the external block
  parameter int unsigned EXT_SELECT_BIT = 14;

  // Routing targets
  typedef enum logic [1:0] {
    DEST_SH,
    DEST_PE,
    DEST_EXT
  } dest_e;

  // Peripheral transaction controller states
  typedef enum logic [1:0] {
    PE_IDLE,
    PE_PENDING,
    PE_GRANTED
  } pe_state_e;

endpackage

// ==== addr_decoder.sv ====
// Combinational address remap and target decode for core data requests
`timescale 1ns/1ps

module addr_decoder #(
  parameter bit REMAP_ADDRESS = 1'b1
) (
  input  demux_pkg::addr_t       data_add_i,
  input  demux_pkg::nibble_t     base_addr_i,
  input  demux_pkg::cluster_id_t cluster_id_i,
  output demux_pkg::addr_t       addr_o,
  output demux_pkg::dest_e       dest_o
);

  demux_pkg::nibble_t top_nibble;
  demux_pkg::region_t cluster_ofs;
  demux_pkg::region_t tcdm_rw;
  demux_pkg::region_t tcdm_ts;
  demux_pkg::region_t dem_per;
  demux_pkg::region_t region;

  // Swap the top nibble with the base nibble in both directions
  if (REMAP_ADDRESS) begin : gen_remap
    always_comb begin
      if (data_add_i[demux_pkg::ADDR_WIDTH-1 -: 4] == base_addr_i) begin
        top_nibble = 4'b0001;
      end else if (data_add_i[demux_pkg::ADDR_WIDTH-1 -: 4] == 4'b0001) begin
        top_nibble = base_addr_i;
      end else begin
        top_nibble = data_add_i[demux_pkg::ADDR_WIDTH-1 -: 4];
      end
    end
  end else begin : gen_no_remap
    assign top_nibble = data_add_i[demux_pkg::ADDR_WIDTH-1 -: 4];
  end

  assign addr_o = {top_nibble, data_add_i[demux_pkg::ADDR_WIDTH-5:0]};

  // Four region tags per cluster
  assign cluster_ofs = {4'b0000, cluster_id_i, 2'b00};
  assign tcdm_rw     = demux_pkg::CLUSTER_REGION_BASE + cluster_ofs + demux_pkg::TCDM_RW_OFS;
  assign tcdm_ts     = demux_pkg::CLUSTER_REGION_BASE + cluster_ofs + demux_pkg::TCDM_TS_OFS;
  assign dem_per     = demux_pkg::CLUSTER_REGION_BASE + cluster_ofs + demux_pkg::DEM_PER_OFS;
  assign region      = addr_o[demux_pkg::ADDR_WIDTH-1 -: 12];

  always_comb begin
    if (region == tcdm_rw || region == tcdm_ts) begin
      dest_o = demux_pkg::DEST_SH;
    end else if (region == dem_per && addr_o[demux_pkg::EXT_SELECT_BIT]) begin
      dest_o = demux_pkg::DEST_EXT;
    end else begin
      // Rest of the map, peripheral region included, goes to the interconnect
      dest_o = demux_pkg::DEST_PE;
    end
  end

endmodule

// ==== demux_router.sv ====
// Request steering, grant select and response return path between the core and three targets
`timescale 1ns/1ps

module demux_router (
  input  logic               clk,
  input  logic               rst_ni,
  input  logic               data_req_i,
  input  demux_pkg::dest_e   dest_i,
  output logic               data_gnt_o,
  output logic               sh_req_o,
  input  logic               sh_gnt_i,
  output logic               ext_req_o,
  input  logic               ext_gnt_i,
  output logic               pe_req_o,
  input  logic               pe_gnt_i,
  input  logic               sh_r_valid_i,
  input  demux_pkg::data_t   sh_r_rdata_i,
  input  logic               ext_r_valid_i,
  input  demux_pkg::data_t   ext_r_rdata_i,
  input  logic               ext_r_opc_i,
  input  logic               pe_r_valid_i,
  input  demux_pkg::data_t   pe_r_rdata_i,
  input  logic               pe_r_opc_i,
  output logic               data_r_valid_o,
  output demux_pkg::data_t   data_r_rdata_o,
  output logic               data_r_opc_o
);

  demux_pkg::dest_e rsp_dest_q;

  // One target request at a time, chosen by the decoded destination
  assign sh_req_o  = data_req_i && (dest_i == demux_pkg::DEST_SH);
  assign ext_req_o = data_req_i && (dest_i == demux_pkg::DEST_EXT);
  assign pe_req_o  = data_req_i && (dest_i == demux_pkg::DEST_PE);

  always_comb begin
    case (dest_i)
      demux_pkg::DEST_SH:  data_gnt_o = sh_gnt_i;
      demux_pkg::DEST_EXT: data_gnt_o = ext_gnt_i;
      demux_pkg::DEST_PE:  data_gnt_o = pe_gnt_i;
      default:             data_gnt_o = 1'b0;
    endcase
  end

  // Destination of the outstanding request steers its response
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_dest_q <= demux_pkg::DEST_SH;
    end else if (data_req_i) begin
      rsp_dest_q <= dest_i;
    end
  end

  always_comb begin
    case (rsp_dest_q)
      demux_pkg::DEST_SH: begin
        data_r_valid_o = sh_r_valid_i;
        data_r_rdata_o = sh_r_rdata_i;
        // Shared memory never flags an error
        data_r_opc_o   = 1'b0;
      end
      demux_pkg::DEST_PE: begin
        data_r_valid_o = pe_r_valid_i;
        data_r_rdata_o = pe_r_rdata_i;
        data_r_opc_o   = pe_r_opc_i;
      end
      demux_pkg::DEST_EXT: begin
        data_r_valid_o = ext_r_valid_i;
        data_r_rdata_o = ext_r_rdata_i;
        data_r_opc_o   = ext_r_opc_i;
      end
      default: begin
        data_r_valid_o = 1'b0;
        data_r_rdata_o = '0;
        data_r_opc_o   = 1'b0;
      end
    endcase
  end

endmodule

// ==== pe_port_ctrl.sv ====
// Peripheral-side transaction FSM with a two-stage response pipeline back to the core
`timescale 1ns/1ps

module pe_port_ctrl (
  input  logic             clk,
  input  logic             rst_ni,
  input  logic             req_i,
  output logic             gnt_o,
  output logic             buf_req_o,
  input  logic             buf_gnt_i,
  input  logic             r_valid_i,
  input  demux_pkg::data_t r_rdata_i,
  input  logic             r_opc_i,
  output logic             rsp_valid_o,
  output demux_pkg::data_t rsp_rdata_o,
  output logic             rsp_opc_o
);

  demux_pkg::pe_state_e state_q, state_d;

  logic             s0_valid_q;
  demux_pkg::data_t s0_rdata_q;
  logic             s0_opc_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= demux_pkg::PE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Core is granted only once the peripheral has answered
  always_comb begin
    state_d = state_q;
    case (state_q)
      demux_pkg::PE_IDLE: begin
        if (req_i && buf_gnt_i) begin
          state_d = demux_pkg::PE_PENDING;
        end
      end
      demux_pkg::PE_PENDING: begin
        if (r_valid_i) begin
          state_d = demux_pkg::PE_GRANTED;
        end
      end
      demux_pkg::PE_GRANTED: state_d = demux_pkg::PE_IDLE;
      default:               state_d = demux_pkg::PE_IDLE;
    endcase
  end

  assign buf_req_o = req_i && (state_q == demux_pkg::PE_IDLE);
  assign gnt_o     = (state_q == demux_pkg::PE_GRANTED);

  // Two response stages, valid one cycle after the grant cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      s0_valid_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      s0_valid_q  <= r_valid_i;
      rsp_valid_o <= s0_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (r_valid_i) begin
      s0_rdata_q <= r_rdata_i;
      s0_opc_q   <= r_opc_i;
    end
    if (s0_valid_q) begin
      rsp_rdata_o <= s0_rdata_q;
      rsp_opc_o   <= s0_opc_q;
    end
  end

endmodule

// ==== periph_req_buffer.sv ====
// One-entry request register between the demux and the peripheral interconnect
`timescale 1ns/1ps

module periph_req_buffer (
  input  logic             clk,
  input  logic             rst_ni,
  input  logic             req_i,
  input  demux_pkg::addr_t add_i,
  input  logic             wen_i,
  input  demux_pkg::data_t wdata_i,
  input  demux_pkg::be_t   be_i,
  output logic             gnt_o,
  output logic             req_o,
  output demux_pkg::addr_t add_o,
  output logic             wen_o,
  output demux_pkg::data_t wdata_o,
  output demux_pkg::be_t   be_o,
  input  logic             gnt_i
);

  logic full_q;
  logic push;
  logic pop;

  // Accept only while empty
  assign gnt_o = !full_q;
  assign push  = req_i && !full_q;
  assign pop   = full_q && gnt_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (pop) begin
      full_q <= 1'b0;
    end
  end

  // Stored request, stable until downstream grant
  always_ff @(posedge clk) begin
    if (push) begin
      add_o   <= add_i;
      wen_o   <= wen_i;
      wdata_o <= wdata_i;
      be_o    <= be_i;
    end
  end

  assign req_o = full_q;

endmodule

// ==== core_demux.sv ====
// Top level of the core data demux: routes requests to shared memory, peripherals or external block
`timescale 1ns/1ps

module core_demux #(
  parameter bit REMAP_ADDRESS = 1'b1
) (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  demux_pkg::nibble_t     base_addr_i,
  input  demux_pkg::cluster_id_t cluster_id_i,

  // Core side
  input  logic                   data_req_i,
  input  demux_pkg::addr_t       data_add_i,
  input  logic                   data_wen_i,
  input  demux_pkg::data_t       data_wdata_i,
  input  demux_pkg::be_t         data_be_i,
  output logic                   data_gnt_o,
  output logic                   data_r_valid_o,
  output demux_pkg::data_t       data_r_rdata_o,
  output logic                   data_r_opc_o,

  // Shared memory
  output logic                   sh_req_o,
  output demux_pkg::addr_t       sh_add_o,
  output logic                   sh_wen_o,
  output demux_pkg::data_t       sh_wdata_o,
  output demux_pkg::be_t         sh_be_o,
  input  logic                   sh_gnt_i,
  input  logic                   sh_r_valid_i,
  input  demux_pkg::data_t       sh_r_rdata_i,

  // External peripherals
  output logic                   ext_req_o,
  output demux_pkg::addr_t       ext_add_o,
  output logic                   ext_wen_o,
  output demux_pkg::data_t       ext_wdata_o,
  output demux_pkg::be_t         ext_be_o,
  input  logic                   ext_gnt_i,
  input  logic                   ext_r_valid_i,
  input  demux_pkg::data_t       ext_r_rdata_i,
  input  logic                   ext_r_opc_i,

  // Peripheral interconnect
  output logic                   pe_req_o,
  output demux_pkg::addr_t       pe_add_o,
  output logic                   pe_wen_o,
  output demux_pkg::data_t       pe_wdata_o,
  output demux_pkg::be_t         pe_be_o,
  input  logic                   pe_gnt_i,
  input  logic                   pe_r_valid_i,
  input  demux_pkg::data_t       pe_r_rdata_i,
  input  logic                   pe_r_opc_i
);

  demux_pkg::addr_t addr_remap;
  demux_pkg::dest_e dest;
  logic             pe_req;
  logic             pe_gnt;
  logic             pe_rsp_valid;
  demux_pkg::data_t pe_rsp_rdata;
  logic             pe_rsp_opc;
  logic             buf_req;
  logic             buf_gnt;

  addr_decoder #(
    .REMAP_ADDRESS ( REMAP_ADDRESS )
  ) i_addr_decoder (
    .data_add_i   ( data_add_i   ),
    .base_addr_i  ( base_addr_i  ),
    .cluster_id_i ( cluster_id_i ),
    .addr_o       ( addr_remap   ),
    .dest_o       ( dest         )
  );

  // Shared memory and external block see the core payload directly
  assign sh_add_o    = addr_remap;
  assign sh_wen_o    = data_wen_i;
  assign sh_wdata_o  = data_wdata_i;
  assign sh_be_o     = data_be_i;
  assign ext_add_o   = addr_remap;
  assign ext_wen_o   = data_wen_i;
  assign ext_wdata_o = data_wdata_i;
  assign ext_be_o    = data_be_i;

  demux_router i_demux_router (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .data_req_i     ( data_req_i     ),
    .dest_i         ( dest           ),
    .data_gnt_o     ( data_gnt_o     ),
    .sh_req_o       ( sh_req_o       ),
    .sh_gnt_i       ( sh_gnt_i       ),
    .ext_req_o      ( ext_req_o      ),
    .ext_gnt_i      ( ext_gnt_i      ),
    .pe_req_o       ( pe_req         ),
    .pe_gnt_i       ( pe_gnt         ),
    .sh_r_valid_i   ( sh_r_valid_i   ),
    .sh_r_rdata_i   ( sh_r_rdata_i   ),
    .ext_r_valid_i  ( ext_r_valid_i  ),
    .ext_r_rdata_i  ( ext_r_rdata_i  ),
    .ext_r_opc_i    ( ext_r_opc_i    ),
    .pe_r_valid_i   ( pe_rsp_valid   ),
    .pe_r_rdata_i   ( pe_rsp_rdata   ),
    .pe_r_opc_i     ( pe_rsp_opc     ),
    .data_r_valid_o ( data_r_valid_o ),
    .data_r_rdata_o ( data_r_rdata_o ),
    .data_r_opc_o   ( data_r_opc_o   )
  );

  pe_port_ctrl i_pe_port_ctrl (
    .clk         ( clk          ),
    .rst_ni      ( rst_ni       ),
    .req_i       ( pe_req       ),
    .gnt_o       ( pe_gnt       ),
    .buf_req_o   ( buf_req      ),
    .buf_gnt_i   ( buf_gnt      ),
    .r_valid_i   ( pe_r_valid_i ),
    .r_rdata_i   ( pe_r_rdata_i ),
    .r_opc_i     ( pe_r_opc_i   ),
    .rsp_valid_o ( pe_rsp_valid ),
    .rsp_rdata_o ( pe_rsp_rdata ),
    .rsp_opc_o   ( pe_rsp_opc   )
  );

  periph_req_buffer i_periph_req_buffer (
    .clk     ( clk          ),
    .rst_ni  ( rst_ni       ),
    .req_i   ( buf_req      ),
    .add_i   ( addr_remap   ),
    .wen_i   ( data_wen_i   ),
    .wdata_i ( data_wdata_i ),
    .be_i    ( data_be_i    ),
    .gnt_o   ( buf_gnt      ),
    .req_o   ( pe_req_o     ),
    .add_o   ( pe_add_o     ),
    .wen_o   ( pe_wen_o     ),
    .wdata_o ( pe_wdata_o   ),
    .be_o    ( pe_be_o      ),
    .gnt_i   ( pe_gnt_i     )
  );

endmodule

// ==== core_demux_asserts.sv ====
// Handshake assertions for the core data demux that bind attaches to the top level
`timescale 1ns/1ps

module core_demux_asserts (
  input logic             clk,
  input logic             rst_ni,
  input logic             sh_req_o,
  input logic             sh_gnt_i,
  input logic             ext_req_o,
  input logic             ext_gnt_i,
  input logic             pe_req_o,
  input logic             pe_req,
  input logic             pe_gnt,
  input logic             data_gnt_o,
  input logic             data_r_valid_o,
  input demux_pkg::dest_e dest
);

  one_target_req: assert property (@(posedge clk) disable iff (!rst_ni)
    $onehot0({sh_req_o, ext_req_o, pe_req_o}))
    else $error("More than one target request is high");

  // Requests stay up until granted
  sh_req_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    (sh_req_o && !sh_gnt_i) |=> sh_req_o)
    else $error("Shared memory request dropped before grant");

  ext_req_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    (ext_req_o && !ext_gnt_i) |=> ext_req_o)
    else $error("External request dropped before grant");

  pe_req_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    (pe_req && !pe_gnt) |=> pe_req)
    else $error("Peripheral request dropped before grant");

  pe_rsp_after_gnt: assert property (@(posedge clk) disable iff (!rst_ni)
    (data_gnt_o && dest == demux_pkg::DEST_PE) |=> data_r_valid_o)
    else $error("Peripheral response did not follow the core grant");

endmodule

bind core_demux core_demux_asserts i_core_demux_asserts (
  .clk            ( clk            ),
  .rst_ni         ( rst_ni         ),
  .sh_req_o       ( sh_req_o       ),
  .sh_gnt_i       ( sh_gnt_i       ),
  .ext_req_o      ( ext_req_o      ),
  .ext_gnt_i      ( ext_gnt_i      ),
  .pe_req_o       ( pe_req_o       ),
  .pe_req         ( pe_req         ),
  .pe_gnt         ( pe_gnt         ),
  .data_gnt_o     ( data_gnt_o     ),
  .data_r_valid_o ( data_r_valid_o ),
  .dest           ( dest           )
);

// ==== tb_clk_gen.sv ====
// Testbench clock and reset source for the core data demux simulation
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset released just after the last reset edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== core_demux_tb.sv ====
// Self-checking testbench for core_demux with random-latency slave models on all three targets
`timescale 1ns/1ps

module core_demux_tb;

  localparam bit                     REMAP = 1'b1;
  localparam demux_pkg::nibble_t     BASE  = 4'hA;
  localparam demux_pkg::cluster_id_t CID   = 6'd3;
  localparam int                     TMO   = 40;

  logic clk;
  logic rst_n;
  int   seed = 32'h202e6c16;
  int   mismatches = 0;
  int   timeouts = 0;

  logic data_req, data_wen, data_gnt_o, data_r_valid_o, data_r_opc_o;
  demux_pkg::addr_t data_add;
  demux_pkg::data_t data_wdata, data_r_rdata_o;
  demux_pkg::be_t   data_be;
  logic sh_req_o, sh_wen_o, sh_gnt, sh_r_valid;
  logic ext_req_o, ext_wen_o, ext_gnt, ext_r_valid, ext_r_opc;
  logic pe_req_o, pe_wen_o, pe_gnt, pe_r_valid, pe_r_opc;
  demux_pkg::addr_t sh_add_o, ext_add_o, pe_add_o;
  demux_pkg::data_t sh_wdata_o, ext_wdata_o, pe_wdata_o;
  demux_pkg::data_t sh_r_rdata, ext_r_rdata, pe_r_rdata;
  demux_pkg::be_t   sh_be_o, ext_be_o, pe_be_o;

  // Expected values of the transaction in flight
  demux_pkg::dest_e cur_dest;
  demux_pkg::addr_t cur_addr;
  demux_pkg::data_t cur_wdata, cur_rdata;
  demux_pkg::be_t   cur_be;
  logic cur_wen, cur_opc, pe_resp_seen;
  logic sh_req_q, ext_req_q, pe_req_q, pe_gnt_q;

  tb_clk_gen #(.PERIOD(20), .RST_CYCLES(3)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  core_demux #(.REMAP_ADDRESS(REMAP)) uut (
    .clk(clk), .rst_ni(rst_n), .base_addr_i(BASE), .cluster_id_i(CID),
    .data_req_i(data_req), .data_add_i(data_add), .data_wen_i(data_wen),
    .data_wdata_i(data_wdata), .data_be_i(data_be), .data_gnt_o(data_gnt_o),
    .data_r_valid_o(data_r_valid_o), .data_r_rdata_o(data_r_rdata_o),
    .data_r_opc_o(data_r_opc_o),
    .sh_req_o(sh_req_o), .sh_add_o(sh_add_o), .sh_wen_o(sh_wen_o), .sh_wdata_o(sh_wdata_o),
    .sh_be_o(sh_be_o), .sh_gnt_i(sh_gnt), .sh_r_valid_i(sh_r_valid), .sh_r_rdata_i(sh_r_rdata),
    .ext_req_o(ext_req_o), .ext_add_o(ext_add_o), .ext_wen_o(ext_wen_o),
    .ext_wdata_o(ext_wdata_o), .ext_be_o(ext_be_o), .ext_gnt_i(ext_gnt),
    .ext_r_valid_i(ext_r_valid), .ext_r_rdata_i(ext_r_rdata), .ext_r_opc_i(ext_r_opc),
    .pe_req_o(pe_req_o), .pe_add_o(pe_add_o), .pe_wen_o(pe_wen_o), .pe_wdata_o(pe_wdata_o),
    .pe_be_o(pe_be_o), .pe_gnt_i(pe_gnt), .pe_r_valid_i(pe_r_valid),
    .pe_r_rdata_i(pe_r_rdata), .pe_r_opc_i(pe_r_opc)
  );

  // Memory map model with nibble swap and region match against the cluster tags
  function automatic demux_pkg::dest_e ref_route(input demux_pkg::addr_t a,
                                                 output demux_pkg::addr_t ra);
    demux_pkg::nibble_t top;
    demux_pkg::region_t rgn, rw;
    top = a[31:28];
    if (REMAP && top == BASE) top = 4'h1;
    else if (REMAP && top == 4'h1) top = BASE;
    ra  = {top, a[27:0]};
    rw  = 12'h100 + {4'b0000, CID, 2'b00};
    rgn = ra[31:20];
    if (rgn == rw || rgn == rw + 12'd1) return demux_pkg::DEST_SH;
    if (rgn == rw + 12'd2 && ra[14]) return demux_pkg::DEST_EXT;
    return demux_pkg::DEST_PE;
  endfunction

  // Each slave model returns the address XORed with its own key
  function automatic demux_pkg::data_t rsp_key(input demux_pkg::dest_e d);
    case (d)
      demux_pkg::DEST_SH:  return 32'h5A5A_0000;
      demux_pkg::DEST_EXT: return 32'h0E0E_1111;
      default:             return 32'hC3C3_2222;
    endcase
  endfunction

  task automatic check_addr(input string what, input demux_pkg::addr_t got, exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_data(input string what, input demux_pkg::data_t got, exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_be(input string what, input demux_pkg::be_t got, exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_dest(input string what, input demux_pkg::dest_e got, exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %s expected %s", $time, what, got.name(), exp.name());
      mismatches++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_quiet();
    check_bit("data_gnt_o in reset", data_gnt_o, 1'b0);
    check_bit("data_r_valid_o in reset", data_r_valid_o, 1'b0);
    check_bit("sh_req_o in reset", sh_req_o, 1'b0);
    check_bit("ext_req_o in reset", ext_req_o, 1'b0);
    check_bit("pe_req_o in reset", pe_req_o, 1'b0);
  endtask

  task automatic end_run();
    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: no %s within %0d cycles at %0t ns", what, TMO, $time);
    timeouts++;
    end_run();
  endtask

  // One core transaction from request through grant to response
  task automatic run_txn(input demux_pkg::addr_t a, input logic wen,
                         input demux_pkg::data_t wd, input demux_pkg::be_t be);
    int n;
    cur_dest     = ref_route(a, cur_addr);
    cur_wen      = wen;
    cur_wdata    = wd;
    cur_be       = be;
    cur_rdata    = cur_addr ^ rsp_key(cur_dest);
    cur_opc      = (cur_dest != demux_pkg::DEST_SH) && cur_addr[2];
    pe_resp_seen = 1'b0;
    data_req     = 1'b1;
    data_add     = a;
    data_wen     = wen;
    data_wdata   = wd;
    data_be      = be;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!data_gnt_o && n < TMO);
    if (!data_gnt_o) report_timeout("core grant");
    #1 data_req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!data_r_valid_o && n < TMO);
    if (!data_r_valid_o) report_timeout("core response");
    #1;
  endtask

  task automatic check_payload(input demux_pkg::dest_e d, input demux_pkg::addr_t a,
                               input demux_pkg::data_t wd, input demux_pkg::be_t be,
                               input logic wen);
    check_dest("target", d, cur_dest);
    check_addr("target address", a, cur_addr);
    check_data("target wdata", wd, cur_wdata);
    check_be("target byte enables", be, cur_be);
    check_bit("target wen", wen, cur_wen);
  endtask

  // Compare process sampled on the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (sh_req_o && !sh_req_q)
        check_payload(demux_pkg::DEST_SH, sh_add_o, sh_wdata_o, sh_be_o, sh_wen_o);
      if (ext_req_o && !ext_req_q)
        check_payload(demux_pkg::DEST_EXT, ext_add_o, ext_wdata_o, ext_be_o, ext_wen_o);
      if (pe_req_o && !pe_req_q)
        check_payload(demux_pkg::DEST_PE, pe_add_o, pe_wdata_o, pe_be_o, pe_wen_o);
      if (data_gnt_o && cur_dest == demux_pkg::DEST_PE)
        check_bit("pe responded before core grant", pe_resp_seen, 1'b1);
      if (pe_gnt_q)
        check_bit("pe response one cycle after grant", data_r_valid_o, 1'b1);
      if (data_r_valid_o) begin
        check_data("core rdata", data_r_rdata_o, cur_rdata);
        check_bit("core error bit", data_r_opc_o, cur_opc);
      end
    end
    sh_req_q  <= sh_req_o;
    ext_req_q <= ext_req_o;
    pe_req_q  <= pe_req_o;
    pe_gnt_q  <= data_gnt_o && cur_dest == demux_pkg::DEST_PE;
  end

  always begin : sh_slave
    int dly;
    demux_pkg::addr_t a;
    @(posedge clk);
    if (rst_n && sh_req_o) begin
      dly = $unsigned($random(seed)) % 4;
      repeat (dly) @(posedge clk);
      #1 sh_gnt = 1'b1;
      @(posedge clk);
      a = sh_add_o;
      #1 sh_gnt = 1'b0;
      dly = $unsigned($random(seed)) % 3;
      repeat (dly) @(posedge clk);
      #1 sh_r_valid = 1'b1;
      sh_r_rdata = a ^ 32'h5A5A_0000;
      @(posedge clk);
      #1 sh_r_valid = 1'b0;
    end
  end

  always begin : ext_slave
    int dly;
    demux_pkg::addr_t a;
    @(posedge clk);
    if (rst_n && ext_req_o) begin
      dly = $unsigned($random(seed)) % 4;
      repeat (dly) @(posedge clk);
      #1 ext_gnt = 1'b1;
      @(posedge clk);
      a = ext_add_o;
      #1 ext_gnt = 1'b0;
      dly = $unsigned($random(seed)) % 3;
      repeat (dly) @(posedge clk);
      #1 ext_r_valid = 1'b1;
      ext_r_rdata = a ^ 32'h0E0E_1111;
      ext_r_opc   = a[2];
      @(posedge clk);
      #1 ext_r_valid = 1'b0;
    end
  end

  always begin : pe_slave
    int dly;
    demux_pkg::addr_t a;
    @(posedge clk);
    if (rst_n && pe_req_o) begin
      dly = $unsigned($random(seed)) % 4;
      repeat (dly) @(posedge clk);
      #1 pe_gnt = 1'b1;
      @(posedge clk);
      a = pe_add_o;
      #1 pe_gnt = 1'b0;
      dly = $unsigned($random(seed)) % 3;
      repeat (dly) @(posedge clk);
      #1 pe_r_valid = 1'b1;
      pe_r_rdata   = a ^ 32'hC3C3_2222;
      pe_r_opc     = a[2];
      pe_resp_seen = 1'b1;
      @(posedge clk);
      #1 pe_r_valid = 1'b0;
    end
  end

  initial begin : stimulus
    int n;
    int sel;
    demux_pkg::addr_t a;
    data_req = 1'b0;
    data_add = '0;
    data_wen = 1'b1;
    data_wdata = '0;
    data_be = 4'hF;
    sh_gnt = 1'b0;
    sh_r_valid = 1'b0;
    sh_r_rdata = '0;
    ext_gnt = 1'b0;
    ext_r_valid = 1'b0;
    ext_r_rdata = '0;
    ext_r_opc = 1'b0;
    pe_gnt = 1'b0;
    pe_r_valid = 1'b0;
    pe_r_rdata = '0;
    pe_r_opc = 1'b0;
    cur_dest = demux_pkg::DEST_SH;
    n = 0;
    while (!rst_n && n < TMO) begin
      @(posedge clk);
      check_quiet();
      n++;
    end
    if (!rst_n) report_timeout("reset release");
    @(posedge clk);
    check_quiet();
    #1;
    // Directed map corners for cluster 3 and base nibble A
    run_txn(32'hA0C0_1230, 1'b1, 32'h0, 4'hF);
    run_txn(32'hA0D0_0044, 1'b0, 32'h1234_5678, 4'h3);
    run_txn(32'hA0E0_4004, 1'b1, 32'h0, 4'hF);
    run_txn(32'hA0E0_0008, 1'b0, 32'hCAFE_0001, 4'hC);
    run_txn(32'h10C0_0010, 1'b1, 32'h0, 4'hF);
    run_txn(32'h3000_0104, 1'b1, 32'h0, 4'h5);
    repeat (60) begin
      sel = $unsigned($random(seed)) % 6;
      a   = $random(seed);
      case (sel)
        0: a[31:20] = 12'hA0C;
        1: a[31:20] = 12'hA0D;
        2: a[31:20] = 12'hA0E;
        3: a[31:20] = 12'h10E;
        default: ;
      endcase
      run_txn(a, 1'($random(seed)), $random(seed), 4'($random(seed)));
    end
    end_run();
  end

endmodule

// ==== all.f ====
demux_pkg.sv
addr_decoder.sv
demux_router.sv
pe_port_ctrl.sv
periph_req_buffer.sv
core_demux.sv
core_demux_asserts.sv
tb_clk_gen.sv
core_demux_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core_demux simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module core_demux_tb -f all.f -o sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1
